//--- all.f
+incdir+dv
rtl/mips_pkg.sv
rtl/instr_decode.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/exec_unit.sv
dv/exec_unit_tb.sv

//--- dv/exec_vectors.svh
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// columns: instruction word, expected out_result, out_dest, out_zero, out_illegal
// result, dest and zero are not compared on rows that expect out_illegal

function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] shamt,
                                           input logic [5:0] funct);
    return {OP_RTYPE, rs, rt, rd, shamt, funct};
endfunction

function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void add_row(input logic [31:0] instr, input logic [31:0] result,
                                input logic [4:0] dest, input logic zero,
                                input logic illegal);
    vec_t row;
    row.instr   = instr;
    row.result  = result;
    row.dest    = dest;
    row.zero    = zero;
    row.illegal = illegal;
    rows.push_back(row);
endfunction

function automatic void load_vectors();
    // known register values built from register zero
    add_row(itype_word(OP_ADDI, 5'd0, 5'd1, 16'h0005), 32'h0000_0005, 5'd1, 1'b0, 1'b0);
    add_row(itype_word(OP_ADDI, 5'd0, 5'd2, 16'hfffd), 32'hffff_fffd, 5'd2, 1'b0, 1'b0);
    add_row(itype_word(OP_ADDI, 5'd0, 5'd3, 16'h7fff), 32'h0000_7fff, 5'd3, 1'b0, 1'b0);
    add_row(itype_word(OP_ADDI, 5'd0, 5'd4, 16'h1234), 32'h0000_1234, 5'd4, 1'b0, 1'b0);
    add_row(itype_word(OP_ADDI, 5'd0, 5'd5, 16'h0000), 32'h0000_0000, 5'd5, 1'b1, 1'b0);
    // every R-type function
    add_row(rtype_word(5'd1, 5'd2, 5'd6, 5'd0, FUNCT6_ADD), 32'h0000_0002, 5'd6, 1'b0, 1'b0);
    add_row(rtype_word(5'd1, 5'd2, 5'd7, 5'd0, FUNCT6_SUB), 32'h0000_0008, 5'd7, 1'b0, 1'b0);
    add_row(rtype_word(5'd3, 5'd4, 5'd8, 5'd0, FUNCT6_AND), 32'h0000_1234, 5'd8, 1'b0, 1'b0);
    add_row(rtype_word(5'd1, 5'd4, 5'd9, 5'd0, FUNCT6_OR), 32'h0000_1235, 5'd9, 1'b0, 1'b0);
    add_row(rtype_word(5'd1, 5'd4, 5'd10, 5'd0, FUNCT6_NOR), 32'hffff_edca, 5'd10, 1'b0, 1'b0);
    add_row(rtype_word(5'd3, 5'd4, 5'd11, 5'd0, FUNCT6_XOR), 32'h0000_6dcb, 5'd11, 1'b0, 1'b0);
    add_row(rtype_word(5'd2, 5'd1, 5'd12, 5'd0, FUNCT6_SLT), 32'h0000_0001, 5'd12, 1'b0, 1'b0);
    add_row(rtype_word(5'd2, 5'd1, 5'd13, 5'd0, FUNCT6_SLTU), 32'h0000_0000, 5'd13, 1'b1, 1'b0);
    add_row(rtype_word(5'd0, 5'd1, 5'd14, 5'd4, FUNCT6_SLL), 32'h0000_0050, 5'd14, 1'b0, 1'b0);
    add_row(rtype_word(5'd0, 5'd2, 5'd15, 5'd28, FUNCT6_SRL), 32'h0000_000f, 5'd15, 1'b0, 1'b0);
    add_row(rtype_word(5'd4, 5'd4, 5'd16, 5'd0, FUNCT6_SUB), 32'h0000_0000, 5'd16, 1'b1, 1'b0);
    // dependent chain, each row reads the one before it
    add_row(itype_word(OP_ADDI, 5'd1, 5'd17, 16'h000a), 32'h0000_000f, 5'd17, 1'b0, 1'b0);
    add_row(rtype_word(5'd17, 5'd17, 5'd18, 5'd0, FUNCT6_ADD), 32'h0000_001e, 5'd18, 1'b0, 1'b0);
    add_row(rtype_word(5'd18, 5'd1, 5'd19, 5'd0, FUNCT6_SUB), 32'h0000_0019, 5'd19, 1'b0, 1'b0);
    add_row(itype_word(OP_ADDI, 5'd19, 5'd19, 16'hffe7), 32'h0000_0000, 5'd19, 1'b1, 1'b0);
    // register zero keeps reading zero after a write to it
    add_row(rtype_word(5'd1, 5'd1, 5'd0, 5'd0, FUNCT6_ADD), 32'h0000_000a, 5'd0, 1'b0, 1'b0);
    add_row(rtype_word(5'd0, 5'd1, 5'd20, 5'd0, FUNCT6_ADD), 32'h0000_0005, 5'd20, 1'b0, 1'b0);
    add_row(rtype_word(5'd0, 5'd2, 5'd26, 5'd0, FUNCT6_OR), 32'hffff_fffd, 5'd26, 1'b0, 1'b0);
    // slti is a signed compare against the immediate
    add_row(itype_word(OP_SLTI, 5'd2, 5'd21, 16'hfffe), 32'h0000_0001, 5'd21, 1'b0, 1'b0);
    add_row(itype_word(OP_SLTI, 5'd1, 5'd22, 16'hffff), 32'h0000_0000, 5'd22, 1'b1, 1'b0);
    add_row(itype_word(OP_SLTI, 5'd2, 5'd23, 16'h7fff), 32'h0000_0001, 5'd23, 1'b0, 1'b0);
    // illegal words, then reads of the registers they name
    add_row(itype_word(6'h3f, 5'd1, 5'd6, 16'h0000), 32'h0000_0000, 5'd0, 1'b0, 1'b1);
    add_row(rtype_word(5'd1, 5'd1, 5'd7, 5'd0, 6'd24), 32'h0000_0000, 5'd0, 1'b0, 1'b1);
    add_row(rtype_word(5'd6, 5'd7, 5'd24, 5'd0, FUNCT6_ADD), 32'h0000_000a, 5'd24, 1'b0, 1'b0);
    add_row(rtype_word(5'd19, 5'd5, 5'd25, 5'd0, FUNCT6_SUB), 32'h0000_0000, 5'd25, 1'b1, 1'b0);
    add_row(rtype_word(5'd7, 5'd6, 5'd27, 5'd0, FUNCT6_SUB), 32'h0000_0006, 5'd27, 1'b0, 1'b0);
endfunction

`endif

//--- dv/exec_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit_tb
    import mips_pkg::*;
;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        zero;
        logic        illegal;
    } vec_t;

    logic        clk_i;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    instr_u      in_instr;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_result;
    logic [4:0]  out_dest;
    logic        out_zero;
    logic        out_illegal;

    vec_t        rows[$];
    vec_t        expected[$];
    int          checked = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    integer      seed = 94251;
    logic        stalled = 1'b0;
    logic [38:0] held;

    `include "exec_vectors.svh"

    exec_unit u_exec_unit (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .out_dest    (out_dest),
        .out_zero    (out_zero),
        .out_illegal (out_illegal)
    );

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp_val, got_val);
        $display("sim failed");
        $fatal(1, "value mismatch");
    endtask

    task automatic abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_output();
        vec_t exp_row;
        assert (expected.size() != 0)
        else
            abort_run("output transfer with no instruction outstanding");
        exp_row = expected.pop_front();
        assert (out_illegal === exp_row.illegal)
        else
            report_mismatch("out_illegal", exp_row.illegal, out_illegal);
        // the result of an illegal word carries no meaning
        if (!exp_row.illegal)
        begin
            assert (out_result === exp_row.result)
            else
                report_mismatch("out_result", exp_row.result, out_result);
            assert (out_dest === exp_row.dest)
            else
                report_mismatch("out_dest", exp_row.dest, out_dest);
            assert (out_zero === exp_row.zero)
            else
                report_mismatch("out_zero", exp_row.zero, out_zero);
        end
        checked++;
    endtask

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial
    begin
        wait (cycle_limit != 0);
        forever
        begin
            @(posedge clk_i);
            cycles++;
            if (cycles >= cycle_limit)
            begin
                abort_run("timeout, not every instruction came out");
            end
        end
    end

    // consumer accepts about three cycles out of four
    initial
    begin
        out_ready = 1'b0;
        wait (rst_n === 1'b1);
        forever
        begin
            @(posedge clk_i);
            #1;
            out_ready = ($random(seed) & 3) != 0;
        end
    end

    // sampled at the falling edge where every signal has settled
    always @(negedge clk_i)
    begin
        if (rst_n)
        begin
            if (stalled)
            begin
                assert (out_valid === 1'b1)
                else
                    abort_run("out_valid dropped while the output was stalled");
                assert ({out_result, out_dest, out_zero, out_illegal} === held)
                else
                    abort_run("output fields changed while the output was stalled");
            end
            if (out_valid && out_ready)
            begin
                check_output();
            end
            stalled = out_valid && !out_ready;
            held    = {out_result, out_dest, out_zero, out_illegal};
        end
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        load_vectors();
        cycle_limit = 20 * rows.size() + 8;

        repeat (8) @(posedge clk_i);
        #1;
        rst_n = 1'b1;

        @(negedge clk_i);
        assert (out_valid === 1'b0)
        else
            report_mismatch("out_valid", 1'b0, out_valid);
        assert (in_ready === 1'b1)
        else
            report_mismatch("in_ready", 1'b1, in_ready);
        @(posedge clk_i);
        #1;

        for (int n = 0; n < rows.size(); n++)
        begin
            in_valid = 1'b1;
            in_instr = rows[n].instr;
            @(negedge clk_i);
            while (!in_ready)
            begin
                @(negedge clk_i);
            end
            // the transfer happens on the coming rising edge
            expected.push_back(rows[n]);
            @(posedge clk_i);
            #1;
        end
        in_valid = 1'b0;

        wait (checked == rows.size());
        // a few idle cycles catch any duplicated output
        repeat (5) @(negedge clk_i);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  logic        clk_i,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [4:0]  shamt,
    input  logic [5:0]  funct,
    input  alu_alt_e    alt_ctrl,
    output logic [31:0] y,
    output logic        zero
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (alt_ctrl)
            ALU_ADD_ALT:
                y = a + b;
            ALU_SUB_ALT:
                y = a - b;
            ALU_SLT_ALT:
                y = {31'd0, lt_signed};
            ALU_DIS_ALT:
            begin
                case (funct)
                    FUNCT6_ADD:
                        y = a + b;
                    FUNCT6_SUB:
                        y = a - b;
                    FUNCT6_AND:
                        y = a & b;
                    FUNCT6_OR:
                        y = a | b;
                    FUNCT6_NOR:
                        y = ~(a | b);
                    FUNCT6_XOR:
                        y = a ^ b;
                    FUNCT6_SLT:
                        y = {31'd0, lt_signed};
                    FUNCT6_SLTU:
                        y = {31'd0, lt_unsigned};
                    // shifts move the rt operand, a is not involved
                    FUNCT6_SLL:
                        y = b << shamt;
                    FUNCT6_SRL:
                        y = b >> shamt;
                    default:
                        y = 32'd0;
                endcase
            end
            default:
                y = 32'd0;
        endcase
    end

    assign zero = (y == 32'd0);

    // the decoder always drives a defined control, even for illegal words
    alt_ctrl_known_a: assert property (
        @(posedge clk_i) !$isunknown(alt_ctrl)
    )
    else
        $error("alu control has unknown bits: %b", alt_ctrl);

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit
    import mips_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n,
    input  logic        in_valid,
    output logic        in_ready,
    input  instr_u      in_instr,
    output logic        out_valid,
    input  logic        out_ready,
    output logic [31:0] out_result,
    output logic [4:0]  out_dest,
    output logic        out_zero,
    output logic        out_illegal
);

    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [4:0]  dec_dest;
    logic [31:0] imm_ext;
    logic        use_imm;
    alu_alt_e    alt_ctrl;
    logic        dec_illegal;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        fwd_ok;
    logic        fwd_rs;
    logic        fwd_rt;
    logic [31:0] op_a;
    logic [31:0] rt_val;
    logic [31:0] op_b;

    logic [31:0] alu_y;
    logic        alu_zero;

    logic        in_fire;
    logic        out_fire;
    logic        wr_en;

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;
    assign out_fire = out_valid && out_ready;

    instr_decode u_instr_decode (
        .instr    (in_instr),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .dest     (dec_dest),
        .imm_ext  (imm_ext),
        .use_imm  (use_imm),
        .alt_ctrl (alt_ctrl),
        .illegal  (dec_illegal)
    );

    // the held entry is only written once the consumer takes it
    assign wr_en = out_fire && !out_illegal && (out_dest != 5'd0);

    reg_file u_reg_file (
        .clk_i   (clk_i),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wr_en   (wr_en),
        .wr_addr (out_dest),
        .wr_data (out_result),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // until it is written back, the output register is the newest copy
    assign fwd_ok = out_valid && !out_illegal && (out_dest != 5'd0);
    assign fwd_rs = fwd_ok && (out_dest == rs_addr);
    assign fwd_rt = fwd_ok && (out_dest == rt_addr);

    assign op_a   = fwd_rs ? out_result : rs_data;
    assign rt_val = fwd_rt ? out_result : rt_data;
    assign op_b   = use_imm ? imm_ext : rt_val;

    alu u_alu (
        .clk_i    (clk_i),
        .a        (op_a),
        .b        (op_b),
        .shamt    (in_instr.r.shamt),
        .funct    (in_instr.r.funct),
        .alt_ctrl (alt_ctrl),
        .y        (alu_y),
        .zero     (alu_zero)
    );

    // loading whenever in_ready is high also drops valid after a plain drain
    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (in_fire)
        begin
            out_result  <= alu_y;
            out_dest    <= dec_dest;
            out_zero    <= alu_zero;
            out_illegal <= dec_illegal;
        end
    end

    // a stalled entry keeps every field until the consumer takes it
    out_stable_a: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_result) && $stable(out_dest)
            && $stable(out_zero) && $stable(out_illegal)
    )
    else
        $error("output changed while stalled");

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode
    import mips_pkg::*;
(
    input  instr_u      instr,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    output logic [4:0]  dest,
    output logic [31:0] imm_ext,
    output logic        use_imm,
    output alu_alt_e    alt_ctrl,
    output logic        illegal
);

    logic funct_ok;

    // source fields sit in the same place for both formats
    assign rs_addr = instr.i.rs;
    assign rt_addr = instr.i.rt;

    assign imm_ext = {{16{instr.i.imm[15]}}, instr.i.imm};

    always_comb
    begin
        case (instr.r.funct)
            FUNCT6_SLL,
            FUNCT6_SRL,
            FUNCT6_ADD,
            FUNCT6_SUB,
            FUNCT6_AND,
            FUNCT6_OR,
            FUNCT6_XOR,
            FUNCT6_NOR,
            FUNCT6_SLT,
            FUNCT6_SLTU: funct_ok = 1'b1;
            default:     funct_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        dest     = 5'd0;
        use_imm  = 1'b0;
        alt_ctrl = ALU_ADD_ALT;
        illegal  = 1'b0;

        case (instr.r.opcode)
            OP_RTYPE:
            begin
                dest     = instr.r.rd;
                alt_ctrl = ALU_DIS_ALT;
                illegal  = !funct_ok;
            end
            OP_ADDI:
            begin
                dest     = instr.i.rt;
                use_imm  = 1'b1;
                alt_ctrl = ALU_ADD_ALT;
            end
            OP_SLTI:
            begin
                dest     = instr.i.rt;
                use_imm  = 1'b1;
                alt_ctrl = ALU_SLT_ALT;
            end
            default:
                illegal = 1'b1;
        endcase

        // an illegal word reports destination zero so nothing can be written
        if (illegal)
        begin
            dest = 5'd0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // major opcodes handled by the execute stage
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_SLTI  = 6'd10;

    // R-type function codes
    localparam logic [5:0] FUNCT6_SLL  = 6'd0;
    localparam logic [5:0] FUNCT6_SRL  = 6'd2;
    localparam logic [5:0] FUNCT6_ADD  = 6'd32;
    localparam logic [5:0] FUNCT6_SUB  = 6'd34;
    localparam logic [5:0] FUNCT6_AND  = 6'd36;
    localparam logic [5:0] FUNCT6_OR   = 6'd37;
    localparam logic [5:0] FUNCT6_XOR  = 6'd38;
    localparam logic [5:0] FUNCT6_NOR  = 6'd39;
    localparam logic [5:0] FUNCT6_SLT  = 6'd42;
    localparam logic [5:0] FUNCT6_SLTU = 6'd43;

    // dispatch means the function field picks the operation
    typedef enum logic [1:0] {
        ALU_ADD_ALT = 2'b00,
        ALU_SUB_ALT = 2'b01,
        ALU_DIS_ALT = 2'b10,
        ALU_SLT_ALT = 2'b11
    } alu_alt_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    // both views share opcode, rs and rt at the same bit positions
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic        clk_i,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= 32'd0;
            end
        end
        else if (wr_en && (wr_addr != 5'd0))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // register zero reads as zero whatever the array holds
    always_comb
    begin
        if (rs_addr == 5'd0)
        begin
            rs_data = 32'd0;
        end
        else
        begin
            rs_data = regs[rs_addr];
        end
    end

    always_comb
    begin
        if (rt_addr == 5'd0)
        begin
            rt_data = 32'd0;
        end
        else
        begin
            rt_data = regs[rt_addr];
        end
    end

    // the top filters out register zero before it issues a write
    no_write_r0_a: assert property (
        @(posedge clk_i) disable iff (!rst_n)
        wr_en |-> (wr_addr != 5'd0)
    )
    else
        $error("write issued to register zero");

endmodule

`default_nettype wire
